// ==== hdl/agen_pkg.sv ====
// memory-op issue side, shared definitions
// queue word layout, op kinds and field widths used by the queue,
// the address-generation units and the testbench
package agen_pkg;

	// ========================================
	// field widths
	// ========================================

	// tag names an op in its result
	localparam int TAG_W = 5;
	localparam int MEM_BASE_W = 20;
	// offset is signed and gets sign-extended in the adder
	localparam int MEM_OFS_W = 14;
	localparam int SYNC_ID_W = 10;
	localparam int SYNC_RSVD_W = MEM_BASE_W + MEM_OFS_W - SYNC_ID_W;

	// ========================================
	// queue word
	// ========================================

	typedef enum logic {
		OP_MEM  = 1'b0,
		OP_SYNC = 1'b1
	} op_kind_e;

	typedef struct packed {
		logic [MEM_BASE_W-1:0] base;
		logic [MEM_OFS_W-1:0]  ofs;
	} mem_body_t;

	// a barrier only carries its id, the rest of the body is spare
	typedef struct packed {
		logic [SYNC_ID_W-1:0]   bar_id;
		logic [SYNC_RSVD_W-1:0] rsvd;
	} sync_body_t;

	// the body is read as a memory op or as a sync, depending on kind
	typedef union packed {
		mem_body_t  mem;
		sync_body_t sync;
	} iq_body_u;

	// this is the dispatch word, 40 bits in all
	typedef struct packed {
		op_kind_e        kind;
		logic [TAG_W-1:0] tag;
		iq_body_u        body;
	} iq_word_t;

	// ========================================
	// configuration addresses
	// ========================================

	localparam logic CFG_ADDR_ENABLE  = 1'b0;
	localparam logic CFG_ADDR_SEGBASE = 1'b1;

endpackage

// ==== hdl/agen_cfg_regs.sv ====
// AGEN configuration registers
// holds the per-unit enable mask and the segment base that is added to
// every effective address, written one register at a time
module agen_cfg_regs #(
	parameter int ADDR_W = 32
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              cfg_we,
	input  logic              cfg_addr,
	input  logic [ADDR_W-1:0] cfg_wdata,
	output logic [1:0]        agen_enable,
	output logic [ADDR_W-1:0] seg_base
);

	// both units come out of reset enabled with a zero segment base
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			agen_enable <= 2'b11;
			seg_base <= '0;
		end else if (cfg_we) begin
			// a write lands on the next edge and is seen by ops issued after it
			if (cfg_addr == agen_pkg::CFG_ADDR_ENABLE) begin
				agen_enable <= cfg_wdata[1:0];
			end else begin
				seg_base <= cfg_wdata;
			end
		end
	end

	// an unknown address would silently hit the segment base register
	a_cfg_addr_known: assert property (@(posedge clk) disable iff (!arst_n)
		cfg_we |-> !$isunknown(cfg_addr));

endmodule

// ==== hdl/issue_queue.sv ====
// memory-op issue queue
// takes decoded words over a four-phase dispatch handshake, keeps the
// slots in age order through the heads list and tracks which slots are
// issued to each AGEN unit, freeing them when the unit reports done
// a sync barrier leaves as soon as it becomes the oldest entry
module issue_queue #(
	parameter  int IQ_ENTRIES = 8,
	localparam int QID_W = $clog2(IQ_ENTRIES)
) (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             disp_req,
	input  agen_pkg::iq_word_t               disp_word,
	output logic                             disp_ack,
	input  logic [IQ_ENTRIES-1:0]            issue0,
	input  logic [IQ_ENTRIES-1:0]            issue1,
	input  logic                             done0,
	input  logic                             done1,
	output logic [IQ_ENTRIES-1:0]            could_issue,
	output logic [IQ_ENTRIES-1:0]            iq_mem,
	output logic [IQ_ENTRIES-1:0]            iq_prior_sync,
	output logic [QID_W-1:0]                 heads [IQ_ENTRIES],
	output logic [agen_pkg::MEM_BASE_W-1:0] op0_base,
	output logic [agen_pkg::MEM_OFS_W-1:0]  op0_ofs,
	output logic [agen_pkg::TAG_W-1:0]      op0_tag,
	output logic [agen_pkg::MEM_BASE_W-1:0] op1_base,
	output logic [agen_pkg::MEM_OFS_W-1:0]  op1_ofs,
	output logic [agen_pkg::TAG_W-1:0]      op1_tag
);

	agen_pkg::iq_word_t    slot_q [IQ_ENTRIES];
	agen_pkg::mem_body_t   mem0;
	agen_pkg::mem_body_t   mem1;
	logic [IQ_ENTRIES-1:0] valid_q;
	logic [IQ_ENTRIES-1:0] issued_q;
	logic [IQ_ENTRIES-1:0] inflight0_q;
	logic [IQ_ENTRIES-1:0] inflight1_q;
	logic [IQ_ENTRIES-1:0] leave;
	logic [QID_W-1:0]      heads_q [IQ_ENTRIES];
	logic [QID_W-1:0]      heads_nxt [IQ_ENTRIES];
	logic [QID_W:0]        cnt_q;
	logic [QID_W:0]        cnt_nxt;
	logic [QID_W:0]        keep_n;
	logic [QID_W-1:0]      free_idx;
	logic                  have_free;
	logic                  accept;
	logic                  sync_retire;
	logic                  seen_sync;

	// ========================================
	// allocation and removal
	// ========================================

	// lowest free slot wins, the scan runs downwards so the last hit is kept
	always_comb begin
		free_idx = '0;
		have_free = 1'b0;
		for (int s = IQ_ENTRIES - 1; s >= 0; s--) begin
			if (!valid_q[s]) begin
				free_idx = QID_W'(s);
				have_free = 1'b1;
			end
		end
	end

	// store only on the first cycle of a new request, a full queue holds ack low
	assign accept = disp_req && !disp_ack && have_free;
	// the oldest entry is a sync, nothing older can still be in flight
	assign sync_retire = (cnt_q != '0) && (slot_q[heads_q[0]].kind == agen_pkg::OP_SYNC);

	always_comb begin
		leave = '0;
		if (sync_retire) begin
			leave[heads_q[0]] = 1'b1;
		end
		if (done0) begin
			leave = leave | inflight0_q;
		end
		if (done1) begin
			leave = leave | inflight1_q;
		end
	end

	// squeeze leaving slots out of the age list and append the new one last
	always_comb begin
		keep_n = '0;
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			heads_nxt[i] = '0;
		end
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			if ((i < cnt_q) && !leave[heads_q[i]]) begin
				heads_nxt[keep_n[QID_W-1:0]] = heads_q[i];
				keep_n = keep_n + 1'b1;
			end
		end
		if (accept) begin
			heads_nxt[keep_n[QID_W-1:0]] = free_idx;
		end
		cnt_nxt = keep_n + (QID_W + 1)'(accept);
	end

	// ========================================
	// status toward the selector
	// ========================================

	// list positions past cnt_q point at slot 0 and are harmless to the walk
	assign heads = heads_q;

	always_comb begin
		for (int s = 0; s < IQ_ENTRIES; s++) begin
			could_issue[s] = valid_q[s] && !issued_q[s];
			iq_mem[s] = valid_q[s] && (slot_q[s].kind == agen_pkg::OP_MEM);
		end
	end

	// every entry younger than the first sync in age order is held back
	always_comb begin
		seen_sync = 1'b0;
		iq_prior_sync = '0;
		for (int i = 0; i < IQ_ENTRIES; i++) begin
			if (i < cnt_q) begin
				iq_prior_sync[heads_q[i]] = seen_sync;
				if (slot_q[heads_q[i]].kind == agen_pkg::OP_SYNC) begin
					seen_sync = 1'b1;
				end
			end
		end
	end

	// operand mux for the two units, driven by the one-hot issue vectors
	always_comb begin
		mem0 = '0;
		mem1 = '0;
		op0_tag = '0;
		op1_tag = '0;
		for (int s = 0; s < IQ_ENTRIES; s++) begin
			if (issue0[s]) begin
				mem0 = slot_q[s].body.mem;
				op0_tag = slot_q[s].tag;
			end
			if (issue1[s]) begin
				mem1 = slot_q[s].body.mem;
				op1_tag = slot_q[s].tag;
			end
		end
	end

	assign op0_base = mem0.base;
	assign op0_ofs = mem0.ofs;
	assign op1_base = mem1.base;
	assign op1_ofs = mem1.ofs;

	// ========================================
	// state
	// ========================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
			issued_q <= '0;
			inflight0_q <= '0;
			inflight1_q <= '0;
			heads_q <= '{default: '0};
			cnt_q <= '0;
			disp_ack <= 1'b0;
		end else begin
			valid_q <= (valid_q & ~leave) | (accept ? (IQ_ENTRIES'(1) << free_idx) : '0);
			issued_q <= (issued_q & ~leave) | issue0 | issue1;
			// each unit remembers its slot so done can free it later
			if (|issue0) begin
				inflight0_q <= issue0;
			end
			if (|issue1) begin
				inflight1_q <= issue1;
			end
			heads_q <= heads_nxt;
			cnt_q <= cnt_nxt;
			if (accept) begin
				disp_ack <= 1'b1;
			end else if (!disp_req) begin
				disp_ack <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			slot_q[free_idx] <= disp_word;
		end
	end

	a_no_double_issue: assert property (@(posedge clk) disable iff (!arst_n)
		((issue0 | issue1) & issued_q) == '0);
	a_done0_issued: assert property (@(posedge clk) disable iff (!arst_n)
		done0 |-> $onehot(inflight0_q & issued_q));
	a_done1_issued: assert property (@(posedge clk) disable iff (!arst_n)
		done1 |-> $onehot(inflight1_q & issued_q));
	// a barrier must carry a known id when it is taken in
	a_sync_id_known: assert property (@(posedge clk) disable iff (!arst_n)
		accept && (disp_word.kind == agen_pkg::OP_SYNC)
			|-> !$isunknown(disp_word.body.sync.bar_id));

endmodule

// ==== hdl/agen_issue.sv ====
// address-generation issue selector
// picks, oldest first, up to two ready memory ops for the two AGEN units
// and never lets a memory op pass an older pending sync
module agen_issue #(
	parameter  int IQ_ENTRIES = 8,
	localparam int QID_W = $clog2(IQ_ENTRIES)
) (
	input  logic                  agen0_idle,
	input  logic                  agen1_idle,
	input  logic [QID_W-1:0]      heads [IQ_ENTRIES],
	input  logic [IQ_ENTRIES-1:0] could_issue,
	input  logic [IQ_ENTRIES-1:0] iq_mem,
	input  logic [IQ_ENTRIES-1:0] iq_prior_sync,
	output logic [IQ_ENTRIES-1:0] issue0,
	output logic [IQ_ENTRIES-1:0] issue1
);

	logic [QID_W-1:0] hd;

	always_comb begin
		issue0 = '0;
		issue1 = '0;
		hd = '0;

		// unit 0 takes the oldest candidate
		if (agen0_idle) begin
			for (int n = 0; n < IQ_ENTRIES; n++) begin
				hd = heads[n];
				if (could_issue[hd] && iq_mem[hd] && !iq_prior_sync[hd]
					&& (issue0 == '0)) begin
					issue0[hd] = 1'b1;
				end
			end
		end

		// unit 1 takes the next one, its idle already folds in the enable bit
		if (agen1_idle) begin
			for (int n = 0; n < IQ_ENTRIES; n++) begin
				hd = heads[n];
				if (could_issue[hd] && iq_mem[hd] && !iq_prior_sync[hd]
					&& !issue0[hd] && (issue1 == '0)) begin
					issue1[hd] = 1'b1;
				end
			end
		end
	end

endmodule

// ==== hdl/agen_unit.sv ====
// address-generation unit
// registers the operands of an issued memory op, forms base plus the
// sign-extended offset, adds the segment base in a second stage and
// returns tag and address over a four-phase result handshake
module agen_unit #(
	parameter int ADDR_W = 32
) (
	input  logic                             clk,
	input  logic                             arst_n,
	input  logic                             start,
	input  logic [agen_pkg::MEM_BASE_W-1:0] base,
	input  logic [agen_pkg::MEM_OFS_W-1:0]  ofs,
	input  logic [agen_pkg::TAG_W-1:0]      tag,
	input  logic [ADDR_W-1:0]                seg_base,
	input  logic                             enable,
	output logic                             idle,
	output logic                             done,
	output logic                             res_req,
	output logic [agen_pkg::TAG_W-1:0]      res_tag,
	output logic [ADDR_W-1:0]                res_addr,
	input  logic                             res_ack
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_OPND,
		ST_SUM,
		ST_REQ,
		ST_DRAIN
	} state_e;

	state_e                           state;
	logic [agen_pkg::MEM_BASE_W-1:0] base_q;
	logic [agen_pkg::MEM_OFS_W-1:0]  ofs_q;
	logic [agen_pkg::TAG_W-1:0]      tag_q;
	logic [ADDR_W-1:0]                part_q;

	// a disabled unit still finishes what it holds but takes nothing new
	assign idle = enable && (state == ST_IDLE);

	// ========================================
	// datapath
	// ========================================

	always_ff @(posedge clk) begin
		if ((state == ST_IDLE) && start) begin
			base_q <= base;
			ofs_q <= ofs;
			tag_q <= tag;
		end
		// first stage, the offset is signed
		if (state == ST_OPND) begin
			part_q <= ADDR_W'(base_q) + ADDR_W'(signed'(ofs_q));
		end
		// second stage, result held until the handshake completes
		if (state == ST_SUM) begin
			res_addr <= part_q + seg_base;
			res_tag <= tag_q;
		end
	end

	// ========================================
	// control and result handshake
	// ========================================

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			res_req <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				ST_IDLE: if (start) state <= ST_OPND;
				ST_OPND: state <= ST_SUM;
				// req rises two edges after the issue edge
				ST_SUM: begin
					res_req <= 1'b1;
					state <= ST_REQ;
				end
				ST_REQ: if (res_ack) begin
					res_req <= 1'b0;
					done <= 1'b1;
					state <= ST_DRAIN;
				end
				// wait for the sink to drop ack before taking a new op
				ST_DRAIN: if (!res_ack) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	a_res_stable: assert property (@(posedge clk) disable iff (!arst_n)
		res_req && $past(res_req) |-> $stable(res_addr));

endmodule

// ==== hdl/agen_top.sv ====
// memory-op issue top level
// ties together the issue queue, the issue selector, the configuration
// registers and the two address-generation units
module agen_top #(
	parameter  int IQ_ENTRIES = 8,
	parameter  int ADDR_W = 32,
	localparam int QID_W = $clog2(IQ_ENTRIES)
) (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic                        disp_req,
	input  agen_pkg::iq_word_t          disp_word,
	output logic                        disp_ack,
	input  logic                        cfg_we,
	input  logic                        cfg_addr,
	input  logic [ADDR_W-1:0]           cfg_wdata,
	output logic                        res0_req,
	output logic [agen_pkg::TAG_W-1:0] res0_tag,
	output logic [ADDR_W-1:0]           res0_addr,
	input  logic                        res0_ack,
	output logic                        res1_req,
	output logic [agen_pkg::TAG_W-1:0] res1_tag,
	output logic [ADDR_W-1:0]           res1_addr,
	input  logic                        res1_ack
);

	logic [1:0]                        agen_enable;
	logic [ADDR_W-1:0]                 seg_base;
	logic [IQ_ENTRIES-1:0]             issue0;
	logic [IQ_ENTRIES-1:0]             issue1;
	logic [IQ_ENTRIES-1:0]             could_issue;
	logic [IQ_ENTRIES-1:0]             iq_mem;
	logic [IQ_ENTRIES-1:0]             iq_prior_sync;
	logic [QID_W-1:0]                  heads [IQ_ENTRIES];
	logic [agen_pkg::MEM_BASE_W-1:0]  op0_base;
	logic [agen_pkg::MEM_OFS_W-1:0]   op0_ofs;
	logic [agen_pkg::TAG_W-1:0]       op0_tag;
	logic [agen_pkg::MEM_BASE_W-1:0]  op1_base;
	logic [agen_pkg::MEM_OFS_W-1:0]   op1_ofs;
	logic [agen_pkg::TAG_W-1:0]       op1_tag;
	logic                              agen0_idle;
	logic                              agen1_idle;
	logic                              done0;
	logic                              done1;

	agen_cfg_regs #(.ADDR_W(ADDR_W)) u_cfg (
		.clk(clk), .arst_n(arst_n),
		.cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.agen_enable(agen_enable), .seg_base(seg_base)
	);

	issue_queue #(.IQ_ENTRIES(IQ_ENTRIES)) u_iq (
		.clk(clk), .arst_n(arst_n),
		.disp_req(disp_req), .disp_word(disp_word), .disp_ack(disp_ack),
		.issue0(issue0), .issue1(issue1), .done0(done0), .done1(done1),
		.could_issue(could_issue), .iq_mem(iq_mem), .iq_prior_sync(iq_prior_sync),
		.heads(heads),
		.op0_base(op0_base), .op0_ofs(op0_ofs), .op0_tag(op0_tag),
		.op1_base(op1_base), .op1_ofs(op1_ofs), .op1_tag(op1_tag)
	);

	agen_issue #(.IQ_ENTRIES(IQ_ENTRIES)) u_sel (
		.agen0_idle(agen0_idle), .agen1_idle(agen1_idle), .heads(heads),
		.could_issue(could_issue), .iq_mem(iq_mem), .iq_prior_sync(iq_prior_sync),
		.issue0(issue0), .issue1(issue1)
	);

	// a unit starts whenever its issue vector names any slot
	agen_unit #(.ADDR_W(ADDR_W)) u_agen0 (
		.clk(clk), .arst_n(arst_n), .start(|issue0),
		.base(op0_base), .ofs(op0_ofs), .tag(op0_tag),
		.seg_base(seg_base), .enable(agen_enable[0]), .idle(agen0_idle), .done(done0),
		.res_req(res0_req), .res_tag(res0_tag), .res_addr(res0_addr), .res_ack(res0_ack)
	);

	agen_unit #(.ADDR_W(ADDR_W)) u_agen1 (
		.clk(clk), .arst_n(arst_n), .start(|issue1),
		.base(op1_base), .ofs(op1_ofs), .tag(op1_tag),
		.seg_base(seg_base), .enable(agen_enable[1]), .idle(agen1_idle), .done(done1),
		.res_req(res1_req), .res_tag(res1_tag), .res_addr(res1_addr), .res_ack(res1_ack)
	);

endmodule

// ==== testbench/tb_agen_top.sv ====
// testbench for the memory-op issue top level
// dispatches random memory ops and sync barriers, acknowledges results
// with random delays and checks every address, tag and ordering rule
// against a reference model kept in tag-indexed tables
module tb_agen_top;

	localparam int IQ_ENTRIES = 8;
	localparam int ADDR_W = 32;
	localparam int NTAGS = 1 << agen_pkg::TAG_W;
	localparam int NGROUPS = 256;
	localparam int WAIT_LIMIT = 2000;

	logic                       clk;
	logic                       arst_n;
	logic                       disp_req;
	agen_pkg::iq_word_t         disp_word;
	logic                       disp_ack;
	logic                       cfg_we;
	logic                       cfg_addr;
	logic [ADDR_W-1:0]          cfg_wdata;
	logic                       res0_req;
	logic [agen_pkg::TAG_W-1:0] res0_tag;
	logic [ADDR_W-1:0]          res0_addr;
	logic                       res0_ack;
	logic                       res1_req;
	logic [agen_pkg::TAG_W-1:0] res1_tag;
	logic [ADDR_W-1:0]          res1_addr;
	logic                       res1_ack;

	// expected result per tag, plus its sync group and dispatch order
	logic [ADDR_W-1:0]          exp_addr [NTAGS];
	bit                         pending [NTAGS];
	int                         exp_group [NTAGS];
	int                         exp_seq [NTAGS];
	// outstanding memory ops per sync group
	int                         grp_left [NGROUPS];
	// results seen by the ack agents, waiting for the compare process
	int                         got_port [$];
	logic [agen_pkg::TAG_W-1:0] got_tag [$];
	logic [ADDR_W-1:0]          got_addr [$];
	logic [31:0]                rng_state;
	logic [ADDR_W-1:0]          cur_seg;
	int                         cur_group;
	int                         op_seq;
	int                         n_mem;
	int                         n_recv;
	int                         n_out;
	int                         n_res0;
	int                         n_res1;
	int                         last_seq0;
	bit                         hold_acks;
	bit                         unit1_off;

	agen_top #(.IQ_ENTRIES(IQ_ENTRIES), .ADDR_W(ADDR_W)) u_dut (
		.clk(clk), .arst_n(arst_n),
		.disp_req(disp_req), .disp_word(disp_word), .disp_ack(disp_ack),
		.cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.res0_req(res0_req), .res0_tag(res0_tag), .res0_addr(res0_addr), .res0_ack(res0_ack),
		.res1_req(res1_req), .res1_tag(res1_tag), .res1_addr(res1_addr), .res1_ack(res1_ack)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ========================================
	// helpers and reference model
	// ========================================

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// effective address is segment base plus base plus the signed offset, wrapping
	function automatic logic [ADDR_W-1:0] ref_addr(input logic [ADDR_W-1:0] seg,
		input logic [agen_pkg::MEM_BASE_W-1:0] base,
		input logic [agen_pkg::MEM_OFS_W-1:0] ofs);
		logic [ADDR_W-1:0] base_x;
		logic [ADDR_W-1:0] ofs_x;
		base_x = {{(ADDR_W - agen_pkg::MEM_BASE_W){1'b0}}, base};
		ofs_x = {{(ADDR_W - agen_pkg::MEM_OFS_W){ofs[agen_pkg::MEM_OFS_W-1]}}, ofs};
		return seg + base_x + ofs_x;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic report_mismatch(input string sig, input logic [ADDR_W-1:0] exp_v,
		input logic [ADDR_W-1:0] act_v);
		abort_run($sformatf("CHECK FAILED time %0t %s expected %0h actual %0h",
			$time, sig, exp_v, act_v));
	endtask

	task automatic write_cfg(input logic addr, input logic [ADDR_W-1:0] data);
		cfg_we <= 1'b1;
		cfg_addr <= addr;
		cfg_wdata <= data;
		@(posedge clk);
		cfg_we <= 1'b0;
		@(posedge clk);
	endtask

	// ========================================
	// dispatch agent
	// ========================================

	task automatic raise_disp(input agen_pkg::iq_word_t w);
		disp_word <= w;
		disp_req <= 1'b1;
	endtask

	// finish the four-phase handshake that raise_disp opened
	task automatic finish_disp();
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
			if (n > WAIT_LIMIT) abort_run("timeout waiting for disp_ack to rise");
		end while (!disp_ack);
		disp_req <= 1'b0;
		n = 0;
		do begin
			@(posedge clk);
			n++;
			if (n > WAIT_LIMIT) abort_run("timeout waiting for disp_ack to drop");
		end while (disp_ack);
	endtask

	// builds a random memory op and records its expected result
	task automatic prepare_mem(output agen_pkg::iq_word_t w);
		logic [31:0] r0;
		logic [31:0] r1;
		logic [agen_pkg::TAG_W-1:0] t;
		int n;
		t = op_seq[agen_pkg::TAG_W-1:0];
		n = 0;
		// a tag is reused only after its previous result came back
		while (pending[t]) begin
			@(posedge clk);
			n++;
			if (n > WAIT_LIMIT) abort_run("timeout waiting for a free tag");
		end
		r0 = xorshift32();
		r1 = xorshift32();
		w.kind = agen_pkg::OP_MEM;
		w.tag = t;
		w.body.mem.base = r0[agen_pkg::MEM_BASE_W-1:0];
		w.body.mem.ofs = r1[agen_pkg::MEM_OFS_W-1:0];
		exp_addr[t] = ref_addr(cur_seg, w.body.mem.base, w.body.mem.ofs);
		exp_group[t] = cur_group;
		exp_seq[t] = op_seq;
		pending[t] = 1'b1;
		grp_left[cur_group]++;
		op_seq++;
		n_mem++;
		n_out++;
	endtask

	task automatic send_mem();
		agen_pkg::iq_word_t w;
		prepare_mem(w);
		raise_disp(w);
		finish_disp();
	endtask

	// every later memory op belongs to the next sync group
	task automatic send_sync();
		agen_pkg::iq_word_t w;
		logic [31:0] r;
		r = xorshift32();
		w.kind = agen_pkg::OP_SYNC;
		w.tag = '0;
		w.body.sync.bar_id = r[agen_pkg::SYNC_ID_W-1:0];
		w.body.sync.rsvd = '0;
		if (cur_group + 1 >= NGROUPS) abort_run("too many sync groups for the model");
		cur_group++;
		raise_disp(w);
		finish_disp();
	endtask

	// roughly one sync in eight ops
	task automatic send_mix(input int count);
		logic [31:0] r;
		for (int i = 0; i < count; i++) begin
			r = xorshift32();
			if (r[2:0] == 3'd0) begin
				send_sync();
			end else begin
				send_mem();
			end
		end
	endtask

	task automatic wait_drained();
		int n;
		n = 0;
		while (n_out != 0 || res0_req || res1_req || res0_ack || res1_ack) begin
			@(posedge clk);
			n++;
			if (n > WAIT_LIMIT) abort_run("timeout waiting for outstanding results");
		end
		repeat (2) @(posedge clk);
	endtask

	// ========================================
	// result agents
	// ========================================

	// acknowledges one result port after 0 to 5 cycles, unless acks are held
	task automatic serve_results(input int p);
		logic                       req;
		logic [agen_pkg::TAG_W-1:0] tag;
		logic [ADDR_W-1:0]          addr;
		logic [31:0]                r;
		int                         n;
		forever begin
			@(posedge clk);
			req = (p == 0) ? res0_req : res1_req;
			if (req && !hold_acks) begin
				r = xorshift32();
				repeat (r % 6) @(posedge clk);
				tag = (p == 0) ? res0_tag : res1_tag;
				addr = (p == 0) ? res0_addr : res1_addr;
				got_port.push_back(p);
				got_tag.push_back(tag);
				got_addr.push_back(addr);
				if (p == 0) res0_ack <= 1'b1;
				else res1_ack <= 1'b1;
				n = 0;
				do begin
					@(posedge clk);
					n++;
					if (n > WAIT_LIMIT) abort_run($sformatf("res%0d_req never dropped", p));
					req = (p == 0) ? res0_req : res1_req;
				end while (req);
				if (p == 0) res0_ack <= 1'b0;
				else res1_ack <= 1'b0;
			end
		end
	endtask

	initial serve_results(0);
	initial serve_results(1);

	// ========================================
	// compare process and monitors
	// ========================================

	initial begin : compare_results
		int                         p;
		logic [agen_pkg::TAG_W-1:0] t;
		logic [ADDR_W-1:0]          a;
		forever begin
			@(posedge clk);
			while (got_tag.size() > 0) begin
				p = got_port.pop_front();
				t = got_tag.pop_front();
				a = got_addr.pop_front();
				assert (pending[t]) else
					abort_run($sformatf("res%0d returned tag %0d that is not outstanding", p, t));
				assert (a == exp_addr[t]) else
					report_mismatch($sformatf("res%0d_addr", p), exp_addr[t], a);
				// no result may overtake an older group across a sync
				for (int g = 0; g < exp_group[t]; g++) begin
					assert (grp_left[g] == 0) else
						abort_run($sformatf("tag %0d passed a sync ahead of older ops", t));
				end
				if (unit1_off) begin
					assert (p == 0) else abort_run("a result came from the disabled unit 1");
					assert (exp_seq[t] > last_seq0) else
						abort_run($sformatf("res0 tag %0d is out of dispatch order", t));
					last_seq0 = exp_seq[t];
				end
				if (p == 0) begin
					n_res0++;
				end else begin
					n_res1++;
				end
				pending[t] = 1'b0;
				grp_left[exp_group[t]]--;
				n_recv++;
				n_out--;
			end
		end
	end

	initial begin : watch_unit1
		forever begin
			@(posedge clk);
			if (unit1_off) begin
				assert (!res1_req) else abort_run("res1_req rose while unit 1 was disabled");
			end
		end
	end

	// ========================================
	// test sequence
	// ========================================

	initial begin : main_seq
		agen_pkg::iq_word_t w;
		arst_n = 1'b0;
		disp_req = 1'b0;
		disp_word = '0;
		cfg_we = 1'b0;
		cfg_addr = 1'b0;
		cfg_wdata = '0;
		res0_ack = 1'b0;
		res1_ack = 1'b0;
		rng_state = 32'd92;
		cur_seg = '0;
		cur_group = 0;
		op_seq = 0;
		n_mem = 0;
		n_recv = 0;
		n_out = 0;
		n_res0 = 0;
		n_res1 = 0;
		last_seq0 = -1;
		hold_acks = 1'b0;
		unit1_off = 1'b0;
		for (int i = 0; i < NTAGS; i++) begin
			pending[i] = 1'b0;
		end
		for (int i = 0; i < NGROUPS; i++) begin
			grp_left[i] = 0;
		end
		repeat (10) @(posedge clk);
		arst_n <= 1'b1;
		repeat (2) @(posedge clk);

		// both units busy with a mixed stream of memory ops and barriers
		send_mix(60);
		wait_drained();
		// with both units enabled the load is shared between the ports
		assert (n_res0 > 0 && n_res1 > 0) else
			abort_run("results did not come out on both result ports");

		// new segment base, seen by every op dispatched after the write
		cur_seg = xorshift32();
		write_cfg(agen_pkg::CFG_ADDR_SEGBASE, cur_seg);
		repeat (16) send_mem();
		wait_drained();

		// unit 1 off, so res0 alone carries everything in dispatch order
		write_cfg(agen_pkg::CFG_ADDR_ENABLE, ADDR_W'(2'b01));
		unit1_off = 1'b1;
		last_seq0 = -1;
		send_mix(24);
		wait_drained();
		unit1_off = 1'b0;
		write_cfg(agen_pkg::CFG_ADDR_ENABLE, ADDR_W'(2'b11));

		// held acks keep every slot busy until the queue is full
		hold_acks = 1'b1;
		repeat (IQ_ENTRIES) send_mem();
		prepare_mem(w);
		raise_disp(w);
		for (int i = 0; i < 20; i++) begin
			@(posedge clk);
			assert (!disp_ack) else abort_run("disp_ack rose while the queue was full");
		end
		hold_acks = 1'b0;
		finish_disp();
		send_mix(20);
		wait_drained();

		if (n_recv == n_mem && n_out == 0) begin
			$display(">>> PASS");
			$finish;
		end else begin
			abort_run($sformatf("%0d of %0d results arrived", n_recv, n_mem));
		end
	end

endmodule

// ==== flist.f ====
hdl/agen_pkg.sv
hdl/agen_cfg_regs.sv
hdl/issue_queue.sv
hdl/agen_issue.sv
hdl/agen_unit.sv
hdl/agen_top.sv
testbench/tb_agen_top.sv

// ==== Makefile ====
# Verilator build and run for the memory-op issue testbench

SIM   ?= verilator
FLAGS ?= --binary --timing --assert -Wno-fatal
TOP   ?= tb_agen_top
FLIST ?= flist.f
BUILD ?= obj_dir
LOG   ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

lint:
	$(SIM) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD) $(LOG)
